// ==== phc_pkg.sv ====
// PHC shared definitions: field widths, register map, channel indices, nominal period math
package phc_pkg;

    localparam int NS_W     = 8;   // Period ns
    localparam int FNS_W    = 32;
    localparam int TOD_NS_W = 30;
    localparam int TOD_S_W  = 48;

    localparam int unsigned NS_PER_S = 1_000_000_000;

    typedef logic [63:0] cmd_word_t;

    // Set-ToD word is {sec, ns}, so only the low 34 bits of seconds travel with it
    localparam int SET_SEC_W = $bits(cmd_word_t) - TOD_NS_W;

    localparam int N_CMD          = 4;
    localparam int CMD_SET_TOD    = 0;  // Highest priority
    localparam int CMD_OFS_TOD    = 1;
    localparam int CMD_SET_PERIOD = 2;
    localparam int CMD_OFS_FNS    = 3;

    typedef logic [6:0] addr_t;

    localparam addr_t REG_STATUS     = 7'h0C;
    localparam addr_t REG_CUR_FNS    = 7'h10;
    localparam addr_t REG_CUR_NS     = 7'h14;
    localparam addr_t REG_CUR_SEC_L  = 7'h18;
    localparam addr_t REG_CUR_SEC_H  = 7'h1C;
    localparam addr_t REG_OFS_TOD    = 7'h50;
    localparam addr_t REG_SET_NS     = 7'h54;
    localparam addr_t REG_SET_SEC_L  = 7'h58;
    localparam addr_t REG_SET_SEC_H  = 7'h5C;
    localparam addr_t REG_OFS_FNS    = 7'h6C;
    localparam addr_t REG_NOM_FNS    = 7'h70;
    localparam addr_t REG_NOM_NS     = 7'h74;
    localparam addr_t REG_PERIOD_FNS = 7'h78;
    localparam addr_t REG_PERIOD_NS  = 7'h7C;

    localparam int STATUS_PEND_LSB = 24;

    function automatic logic [NS_W-1:0] nominal_ns(input int unsigned num,
                                                   input int unsigned denom);
        return NS_W'(num / denom);
    endfunction

    function automatic logic [FNS_W-1:0] nominal_fns(input int unsigned num,
                                                     input int unsigned denom);
        logic [63:0] rem;
        rem = 64'(num % denom);
        return FNS_W'((rem << FNS_W) / 64'(denom));  // Remainder scaled to 2^-32 ns
    endfunction

endpackage

// ==== phc_cmd_channel.sv ====
// PHC command channel: holds one armed command word until the clock core grants it
module phc_cmd_channel (
    input  logic               clk,
    input  logic               ptp_rst,
    input  logic               arm,
    input  phc_pkg::cmd_word_t arm_payload,
    input  logic               grant,
    output logic               pending,
    output phc_pkg::cmd_word_t payload
);

    always_ff @(posedge clk) begin
        if (arm && !pending) begin
            pending <= 1'b1;
            payload <= arm_payload;  // Later arms are dropped until granted
        end else if (grant) begin
            pending <= 1'b0;
        end

        if (ptp_rst) begin
            pending <= 1'b0;
        end
    end

    // Core only grants a channel that is holding a command
    grant_needs_pending: assert property (
        @(posedge clk) disable iff (ptp_rst)
        grant |-> pending
    );

endmodule

// ==== phc_reg_file.sv ====
// PHC register file: decodes host writes into staged commands, arms channels, serves reads
module phc_reg_file #(
    parameter int PERIOD_NS_NUM   = 32,
    parameter int PERIOD_NS_DENOM = 5
) (
    input  logic                                      clk,
    input  logic                                      ptp_rst,
    input  logic                                      wr_en,
    input  phc_pkg::addr_t                            wr_addr,
    input  logic [31:0]                               wr_data,
    input  logic                                      rd_en,
    input  phc_pkg::addr_t                            rd_addr,
    input  logic [phc_pkg::N_CMD-1:0]                 pending,
    input  logic [phc_pkg::TOD_S_W-1:0]               tod_s,
    input  logic [phc_pkg::TOD_NS_W-1:0]              tod_ns,
    input  logic [phc_pkg::FNS_W-1:0]                 tod_fns,
    output logic                                      rd_valid,
    output logic [31:0]                               rd_data,
    output logic [phc_pkg::N_CMD-1:0]                 arm,
    output phc_pkg::cmd_word_t [phc_pkg::N_CMD-1:0]   arm_payload
);

    localparam logic [phc_pkg::NS_W-1:0] NOM_NS =
        phc_pkg::nominal_ns(PERIOD_NS_NUM, PERIOD_NS_DENOM);
    localparam logic [phc_pkg::FNS_W-1:0] NOM_FNS =
        phc_pkg::nominal_fns(PERIOD_NS_NUM, PERIOD_NS_DENOM);

    logic [phc_pkg::TOD_NS_W-1:0] set_ns;
    logic [phc_pkg::TOD_S_W-1:0]  set_s;
    logic [phc_pkg::TOD_NS_W-1:0] ofs_tod_ns;
    logic [phc_pkg::FNS_W-1:0]    ofs_fns;
    logic [phc_pkg::NS_W-1:0]     period_ns;
    logic [phc_pkg::FNS_W-1:0]    period_fns;
    phc_pkg::addr_t               wr_word;
    phc_pkg::addr_t               rd_word;
    logic [31:0]                  rd_mux;

    assign wr_word = {wr_addr[6:2], 2'b00};  // Word aligned
    assign rd_word = {rd_addr[6:2], 2'b00};

    always_ff @(posedge clk) begin
        arm <= '0;

        if (wr_en) begin
            case (wr_word)
                phc_pkg::REG_OFS_TOD: begin
                    ofs_tod_ns <= wr_data[phc_pkg::TOD_NS_W-1:0];
                    arm[phc_pkg::CMD_OFS_TOD] <= wr_data[phc_pkg::TOD_NS_W-1:0] != '0;
                end
                phc_pkg::REG_SET_NS: set_ns <= wr_data[phc_pkg::TOD_NS_W-1:0];
                phc_pkg::REG_SET_SEC_L: set_s[31:0] <= wr_data;
                phc_pkg::REG_SET_SEC_H: begin
                    set_s[phc_pkg::TOD_S_W-1:32] <= wr_data[phc_pkg::TOD_S_W-33:0];
                    arm[phc_pkg::CMD_SET_TOD] <= 1'b1;
                end
                phc_pkg::REG_OFS_FNS: begin
                    ofs_fns <= wr_data;
                    arm[phc_pkg::CMD_OFS_FNS] <= wr_data != '0;
                end
                phc_pkg::REG_PERIOD_FNS: period_fns <= wr_data;
                phc_pkg::REG_PERIOD_NS: begin
                    period_ns <= wr_data[phc_pkg::NS_W-1:0];
                    arm[phc_pkg::CMD_SET_PERIOD] <= 1'b1;
                end
                default: begin
                end
            endcase
        end

        if (ptp_rst) begin
            arm        <= '0;
            period_ns  <= NOM_NS;
            period_fns <= NOM_FNS;
        end
    end

    // Payload follows the staged copy, channel samples it with the arm strobe
    assign arm_payload[phc_pkg::CMD_SET_TOD] = {set_s[phc_pkg::SET_SEC_W-1:0], set_ns};
    assign arm_payload[phc_pkg::CMD_OFS_TOD] = phc_pkg::cmd_word_t'(ofs_tod_ns);
    assign arm_payload[phc_pkg::CMD_SET_PERIOD] = phc_pkg::cmd_word_t'({period_ns, period_fns});
    assign arm_payload[phc_pkg::CMD_OFS_FNS] = phc_pkg::cmd_word_t'(ofs_fns);

    always_comb begin
        rd_mux = '0;
        case (rd_word)
            phc_pkg::REG_STATUS:
                rd_mux[phc_pkg::STATUS_PEND_LSB +: phc_pkg::N_CMD] = pending;
            phc_pkg::REG_CUR_FNS:    rd_mux = tod_fns;
            phc_pkg::REG_CUR_NS:     rd_mux = 32'(tod_ns);
            phc_pkg::REG_CUR_SEC_L:  rd_mux = tod_s[31:0];
            phc_pkg::REG_CUR_SEC_H:  rd_mux = 32'(tod_s[phc_pkg::TOD_S_W-1:32]);
            phc_pkg::REG_OFS_TOD:    rd_mux = 32'(ofs_tod_ns);
            phc_pkg::REG_SET_NS:     rd_mux = 32'(set_ns);
            phc_pkg::REG_SET_SEC_L:  rd_mux = set_s[31:0];
            phc_pkg::REG_SET_SEC_H:  rd_mux = 32'(set_s[phc_pkg::TOD_S_W-1:32]);
            phc_pkg::REG_OFS_FNS:    rd_mux = ofs_fns;
            phc_pkg::REG_NOM_FNS:    rd_mux = NOM_FNS;
            phc_pkg::REG_NOM_NS:     rd_mux = 32'(NOM_NS);
            phc_pkg::REG_PERIOD_FNS: rd_mux = period_fns;
            phc_pkg::REG_PERIOD_NS:  rd_mux = 32'(period_ns);
            default:                 rd_mux = '0;  // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        rd_valid <= rd_en;
        if (rd_en) begin
            rd_data <= rd_mux;
        end

        if (ptp_rst) begin
            rd_valid <= 1'b0;
        end
    end

endmodule

// ==== phc_core.sv ====
// PHC clock core: applies granted commands one per cycle and advances the ToD counter
module phc_core #(
    parameter int PERIOD_NS_NUM   = 32,
    parameter int PERIOD_NS_DENOM = 5
) (
    input  logic                                      clk,
    input  logic                                      ptp_rst,
    input  logic [phc_pkg::N_CMD-1:0]                 pending,
    input  phc_pkg::cmd_word_t [phc_pkg::N_CMD-1:0]   payload,
    output logic [phc_pkg::N_CMD-1:0]                 grant,
    output logic [phc_pkg::TOD_S_W-1:0]               tod_s,
    output logic [phc_pkg::TOD_NS_W-1:0]              tod_ns,
    output logic [phc_pkg::FNS_W-1:0]                 tod_fns
);

    logic [phc_pkg::NS_W-1:0]     period_ns;
    logic [phc_pkg::FNS_W-1:0]    period_fns;
    phc_pkg::cmd_word_t           cmd;
    logic [phc_pkg::FNS_W-1:0]    add_fns;
    logic [phc_pkg::TOD_NS_W-1:0] add_ns;
    logic [phc_pkg::FNS_W:0]      fns_sum;
    logic [31:0]                  ns_sum;
    logic [31:0]                  ns_wrap;
    logic [1:0]                   s_inc;
    logic [phc_pkg::TOD_NS_W-1:0] cmd_ns;
    logic [31:0]                  cmd_ns_wrap;

    assign grant = pending & (~pending + 1'b1);  // Lowest pending index wins

    always_comb begin
        cmd = '0;
        for (int i = 0; i < phc_pkg::N_CMD; i++) begin
            if (grant[i]) begin
                cmd = payload[i];
            end
        end
    end

    // Offsets take the place of this cycle's advance
    always_comb begin
        add_fns = period_fns;
        add_ns  = {{(phc_pkg::TOD_NS_W-phc_pkg::NS_W){1'b0}}, period_ns};
        if (grant[phc_pkg::CMD_OFS_TOD]) begin
            add_fns = '0;
            add_ns  = cmd[phc_pkg::TOD_NS_W-1:0];
        end else if (grant[phc_pkg::CMD_OFS_FNS]) begin
            add_fns = cmd[phc_pkg::FNS_W-1:0];
            add_ns  = '0;
        end

        fns_sum = {1'b0, tod_fns} + {1'b0, add_fns};
        ns_sum  = 32'(tod_ns) + 32'(add_ns) + 32'(fns_sum[phc_pkg::FNS_W]);

        // A 30-bit offset can cross the second boundary twice
        if (ns_sum >= 2 * phc_pkg::NS_PER_S) begin
            ns_wrap = ns_sum - 2 * phc_pkg::NS_PER_S;
            s_inc   = 2'd2;
        end else if (ns_sum >= phc_pkg::NS_PER_S) begin
            ns_wrap = ns_sum - phc_pkg::NS_PER_S;
            s_inc   = 2'd1;
        end else begin
            ns_wrap = ns_sum;
            s_inc   = 2'd0;
        end
    end

    // Out of range set value folded back into the second
    assign cmd_ns = cmd[phc_pkg::TOD_NS_W-1:0];
    assign cmd_ns_wrap = (32'(cmd_ns) >= phc_pkg::NS_PER_S) ?
                         32'(cmd_ns) - phc_pkg::NS_PER_S : 32'(cmd_ns);

    always_ff @(posedge clk) begin
        tod_fns <= fns_sum[phc_pkg::FNS_W-1:0];
        tod_ns  <= ns_wrap[phc_pkg::TOD_NS_W-1:0];
        tod_s   <= tod_s + {{(phc_pkg::TOD_S_W-2){1'b0}}, s_inc};

        if (grant[phc_pkg::CMD_SET_TOD]) begin
            tod_s <= {{(phc_pkg::TOD_S_W-phc_pkg::SET_SEC_W){1'b0}},
                      cmd[phc_pkg::TOD_NS_W +: phc_pkg::SET_SEC_W]};
            tod_ns  <= cmd_ns_wrap[phc_pkg::TOD_NS_W-1:0];
            tod_fns <= '0;
        end

        if (grant[phc_pkg::CMD_SET_PERIOD]) begin
            period_ns  <= cmd[phc_pkg::FNS_W +: phc_pkg::NS_W];
            period_fns <= cmd[phc_pkg::FNS_W-1:0];  // New rate from next cycle
        end

        if (ptp_rst) begin
            period_ns  <= phc_pkg::nominal_ns(PERIOD_NS_NUM, PERIOD_NS_DENOM);
            period_fns <= phc_pkg::nominal_fns(PERIOD_NS_NUM, PERIOD_NS_DENOM);
            tod_s      <= '0;
            tod_ns     <= '0;
            tod_fns    <= '0;
        end
    end

    tod_ns_in_range: assert property (
        @(posedge clk) disable iff (ptp_rst)
        32'(tod_ns) < phc_pkg::NS_PER_S
    );

endmodule

// ==== phc_regs.sv ====
// PHC control front end: register file, command channels and clock core with ToD output
module phc_regs #(
    parameter int PERIOD_NS_NUM   = 32,
    parameter int PERIOD_NS_DENOM = 5
) (
    input  logic                         clk,
    input  logic                         ptp_rst,
    input  logic                         wr_en,
    input  phc_pkg::addr_t               wr_addr,
    input  logic [31:0]                  wr_data,
    input  logic                         rd_en,
    input  phc_pkg::addr_t               rd_addr,
    output logic                         rd_valid,
    output logic [31:0]                  rd_data,
    output logic [phc_pkg::TOD_S_W-1:0]  tod_s,
    output logic [phc_pkg::TOD_NS_W-1:0] tod_ns,
    output logic [phc_pkg::FNS_W-1:0]    tod_fns
);

    logic [phc_pkg::N_CMD-1:0]               arm;
    phc_pkg::cmd_word_t [phc_pkg::N_CMD-1:0] arm_payload;
    logic [phc_pkg::N_CMD-1:0]               pending;
    phc_pkg::cmd_word_t [phc_pkg::N_CMD-1:0] payload;
    logic [phc_pkg::N_CMD-1:0]               grant;

    phc_reg_file #(
        .PERIOD_NS_NUM   (PERIOD_NS_NUM),
        .PERIOD_NS_DENOM (PERIOD_NS_DENOM)
    ) reg_file_inst (
        .clk         (clk),
        .ptp_rst     (ptp_rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .pending     (pending),
        .tod_s       (tod_s),
        .tod_ns      (tod_ns),
        .tod_fns     (tod_fns),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .arm         (arm),
        .arm_payload (arm_payload)
    );

    for (genvar i = 0; i < phc_pkg::N_CMD; i++) begin : g_chan
        phc_cmd_channel chan_inst (
            .clk         (clk),
            .ptp_rst     (ptp_rst),
            .arm         (arm[i]),
            .arm_payload (arm_payload[i]),
            .grant       (grant[i]),
            .pending     (pending[i]),
            .payload     (payload[i])
        );
    end

    phc_core #(
        .PERIOD_NS_NUM   (PERIOD_NS_NUM),
        .PERIOD_NS_DENOM (PERIOD_NS_DENOM)
    ) core_inst (
        .clk     (clk),
        .ptp_rst (ptp_rst),
        .pending (pending),
        .payload (payload),
        .grant   (grant),
        .tod_s   (tod_s),
        .tod_ns  (tod_ns),
        .tod_fns (tod_fns)
    );

endmodule

// ==== tb_phc_regs.sv ====
// PHC front end testbench: table-driven register access with a ToD reference model
module tb_phc_regs;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_FREEZE, OP_IDLE, OP_TOD} op_e;

    typedef struct packed {
        op_e            kind;
        phc_pkg::addr_t addr;
        logic [31:0]    data;
        logic [7:0]     cycles;
    } step_t;

    localparam logic [63:0] NS_PER_S_64 = 64'd1_000_000_000;
    localparam logic [31:0] NOM_NS_EXP  = 32'd6;           // 32 / 5 = 6.4 ns
    localparam logic [31:0] NOM_FNS_EXP = 32'h6666_6666;   // 0.4 * 2^32
    localparam logic [31:0] SEED        = 32'h5ed5_257d;

    logic                         clk;
    logic                         ptp_rst;
    logic                         wr_en;
    phc_pkg::addr_t               wr_addr;
    logic [31:0]                  wr_data;
    logic                         rd_en;
    phc_pkg::addr_t               rd_addr;
    logic                         rd_valid;
    logic [31:0]                  rd_data;
    logic [phc_pkg::TOD_S_W-1:0]  tod_s;
    logic [phc_pkg::TOD_NS_W-1:0] tod_ns;
    logic [phc_pkg::FNS_W-1:0]    tod_fns;

    step_t       steps[$];
    logic [31:0] lcg_state;
    logic [31:0] last_rd;

    phc_regs DUT (
        .clk      (clk),
        .ptp_rst  (ptp_rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .tod_s    (tod_s),
        .tod_ns   (tod_ns),
        .tod_fns  (tod_fns)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic push_step(input op_e kind, input phc_pkg::addr_t addr,
                             input logic [31:0] data, input logic [7:0] cycles);
        step_t s;
        s.kind   = kind;
        s.addr   = addr;
        s.data   = data;
        s.cycles = cycles;
        steps.push_back(s);
    endtask

    // Reads land on consecutive edges, so each one sees the counter one step further
    task automatic push_tod_reads(input logic [63:0] total, input logic [63:0] step);
        logic [63:0] sec_l;
        logic [63:0] sec_h;
        sec_l = (total + step) / NS_PER_S_64;
        sec_h = (total + step + step) / NS_PER_S_64;
        push_step(OP_RD, phc_pkg::REG_CUR_NS, 32'(total % NS_PER_S_64), 8'd0);
        push_step(OP_RD, phc_pkg::REG_CUR_SEC_L, sec_l[31:0], 8'd0);
        push_step(OP_RD, phc_pkg::REG_CUR_SEC_H, 32'(sec_h[47:32]), 8'd0);
    endtask

    // ToD output ports while the counter stands still
    task automatic push_tod_outputs(input logic [63:0] total);
        logic [63:0] sec;
        sec = total / NS_PER_S_64;
        push_step(OP_TOD, phc_pkg::REG_CUR_NS, 32'(total % NS_PER_S_64), 8'd0);
        push_step(OP_TOD, phc_pkg::REG_CUR_SEC_L, sec[31:0], 8'd0);
        push_step(OP_TOD, phc_pkg::REG_CUR_SEC_H, 32'(sec[47:32]), 8'd0);
        push_step(OP_TOD, phc_pkg::REG_CUR_FNS, 32'h0, 8'd0);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [63:0] total;
        push_step(OP_RD, phc_pkg::REG_STATUS, 32'h0, 8'd0);
        push_step(OP_RD, phc_pkg::REG_PERIOD_NS, NOM_NS_EXP, 8'd0);
        push_step(OP_RD, phc_pkg::REG_PERIOD_FNS, NOM_FNS_EXP, 8'd0);
        push_step(OP_RD, phc_pkg::REG_NOM_NS, NOM_NS_EXP, 8'd0);
        push_step(OP_RD, phc_pkg::REG_NOM_FNS, NOM_FNS_EXP, 8'd0);
        r = next_rand();
        push_step(OP_WR, phc_pkg::REG_SET_NS, r, 8'd0);
        push_step(OP_RD, phc_pkg::REG_SET_NS, r & 32'h3fff_ffff, 8'd0);  // 30-bit field
        r = next_rand();
        push_step(OP_WR, phc_pkg::REG_SET_SEC_L, r, 8'd0);
        push_step(OP_RD, phc_pkg::REG_SET_SEC_L, r, 8'd0);
        r = next_rand();
        push_step(OP_WR, phc_pkg::REG_OFS_TOD, r, 8'd0);
        push_step(OP_RD, phc_pkg::REG_OFS_TOD, r & 32'h3fff_ffff, 8'd0);
        r = next_rand();
        push_step(OP_WR, phc_pkg::REG_OFS_FNS, r, 8'd0);
        push_step(OP_RD, phc_pkg::REG_OFS_FNS, r, 8'd0);

        // Stop the counter, then load a known time
        v = next_rand() % 32'd500_000_000;
        a = next_rand();
        push_step(OP_WR, phc_pkg::REG_PERIOD_FNS, 32'h0, 8'd0);
        push_step(OP_WR, phc_pkg::REG_PERIOD_NS, 32'h0, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_NS, v, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_SEC_L, a, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_SEC_H, 32'h1, 8'd0);
        push_step(OP_IDLE, phc_pkg::REG_STATUS, 32'h0, 8'd3);
        push_step(OP_RD, phc_pkg::REG_CUR_NS, v, 8'd0);
        push_step(OP_FREEZE, phc_pkg::REG_CUR_NS, 32'h0, 8'd6);
        push_step(OP_RD, phc_pkg::REG_CUR_FNS, 32'h0, 8'd0);
        total = (64'h1_0000_0000 + 64'(a)) * NS_PER_S_64 + 64'(v);
        push_tod_reads(total, 64'd0);
        push_tod_outputs(total);

        // Offsets with the counter stopped and the second one crossing a second
        d1 = 32'd1 + next_rand() % 32'd100_000_000;
        push_step(OP_WR, phc_pkg::REG_OFS_TOD, d1, 8'd0);
        push_step(OP_IDLE, phc_pkg::REG_STATUS, 32'h0, 8'd2);
        total = total + 64'(d1);
        push_tod_reads(total, 64'd0);
        push_tod_outputs(total);
        d2 = 32'd1_000_000_000 - (v + d1) + next_rand() % 32'd1000;
        push_step(OP_WR, phc_pkg::REG_OFS_TOD, d2, 8'd0);
        push_step(OP_IDLE, phc_pkg::REG_STATUS, 32'h0, 8'd2);
        total = total + 64'(d2);
        push_tod_reads(total, 64'd0);
        push_tod_outputs(total);

        // 4 ns period from just below the second boundary
        a = next_rand();
        push_step(OP_WR, phc_pkg::REG_PERIOD_FNS, 32'h0, 8'd0);
        push_step(OP_WR, phc_pkg::REG_PERIOD_NS, 32'h4, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_NS, 32'd999_999_990, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_SEC_L, a, 8'd0);
        push_step(OP_WR, phc_pkg::REG_SET_SEC_H, 32'h0, 8'd0);
        push_step(OP_IDLE, phc_pkg::REG_STATUS, 32'h0, 8'd10);
        total = 64'(a) * NS_PER_S_64 + 64'd999_999_990 + 64'd32;  // 8 steps since the set
        push_tod_reads(total, 64'd4);
        push_step(OP_RD, phc_pkg::REG_STATUS, 32'h0, 8'd0);
    endtask

    task automatic wait_cycles(input logic [7:0] n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic read_reg(input phc_pkg::addr_t addr, output logic [31:0] data);
        int waited;
        rd_en   = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        rd_en  = 1'b0;
        waited = 0;
        while (rd_valid !== 1'b1 && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (rd_valid === 1'b1) else report_failure("Read request got no rd_valid pulse");
        data    = rd_data;
        last_rd = rd_data;
    endtask

    task automatic check_read(input phc_pkg::addr_t addr, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else report_failure(
            $sformatf("MISMATCH rd_data at addr %h: got %h, expected %h", addr, got, exp));
    endtask

    task automatic check_tod(input phc_pkg::addr_t which, input logic [31:0] exp);
        logic [31:0] got;
        string       name;
        case (which)
            phc_pkg::REG_CUR_FNS: begin
                got  = tod_fns;
                name = "tod_fns";
            end
            phc_pkg::REG_CUR_NS: begin
                got  = 32'(tod_ns);
                name = "tod_ns";
            end
            phc_pkg::REG_CUR_SEC_L: begin
                got  = tod_s[31:0];
                name = "tod_s[31:0]";
            end
            default: begin
                got  = 32'(tod_s[phc_pkg::TOD_S_W-1:32]);
                name = "tod_s[47:32]";
            end
        endcase
        assert (got === exp) else report_failure(
            $sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] got;
        logic [31:0] prev;
        case (s.kind)
            OP_WR: begin
                wr_en   = 1'b1;
                wr_addr = s.addr;
                wr_data = s.data;
                @(posedge clk);
                #1;
                wr_en = 1'b0;
            end
            OP_RD: begin
                read_reg(s.addr, got);
                check_read(s.addr, got, s.data);
            end
            OP_FREEZE: begin
                prev = last_rd;  // Must not move while the period is zero
                wait_cycles(s.cycles);
                read_reg(s.addr, got);
                check_read(s.addr, got, prev);
            end
            OP_TOD: check_tod(s.addr, s.data);
            default: wait_cycles(s.cycles);
        endcase
    endtask

    initial begin
        #1;
        repeat (steps.size() * 20) @(posedge clk);
        report_failure("Watchdog expired before the step table finished");
    end

    initial begin
        clk       = 1'b0;
        ptp_rst   = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        lcg_state = SEED;
        last_rd   = '0;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        ptp_rst = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== phc_regs.f ====
phc_pkg.sv
phc_cmd_channel.sv
phc_reg_file.sv
phc_core.sv
phc_regs.sv
tb_phc_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the phc_regs testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f phc_regs.f \
    --top-module tb_phc_regs \
    -Mdir obj_dir

# The log decides the verdict, so a failing run must not stop the script here
./obj_dir/Vtb_phc_regs > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
